/* compile.f */
ctrl_pkg.sv
ctrl_exc_prio.sv
ctrl_irq.sv
ctrl_fsm.sv
ctrl_top.sv
ctrl_properties.sv
tb_clk_gen.sv
ctrl_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = ctrl_tb
FILELIST  = compile.f
OBJDIR    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -qx "sim passed"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

/* ctrl_tb.sv */
`timescale 1ns/10ps

module ctrl_tb;

	localparam int unsigned NumFastIrq = 15;
	localparam int NumTxn = 60;
	localparam int CycleLimit = 40 * NumTxn + 100;

	logic clk_i, rst_ni;
	logic ctrl_busy_o, illegal_insn_i, ecall_insn_i, mret_insn_i, wfi_insn_i, ebrk_insn_i;
	logic csr_pipe_flush_i, instr_valid_i, instr_is_compressed_i, instr_fetch_err_i;
	logic instr_fetch_err_plus2_i, instr_valid_clear_o, id_in_ready_o, instr_req_o, pc_set_o;
	logic [31:0] instr_i, pc_id_i, lsu_addr_last_i, csr_mtval_o;
	logic [15:0] instr_compressed_i;
	ctrl_pkg::pc_sel_e pc_mux_o;
	ctrl_pkg::exc_pc_sel_e exc_pc_mux_o;
	ctrl_pkg::exc_cause_t exc_cause_o;
	logic load_err_i, store_err_i, branch_set_i, jump_set_i, csr_mstatus_mie_i, irq_pending_i;
	logic [NumFastIrq+2:0] irqs_i;
	logic irq_nm_i, nmi_mode_o, csr_save_if_o, csr_save_id_o, csr_save_cause_o;
	logic csr_restore_mret_o, stall_id_i, flush_id_o;
	logic [1:0] priv_mode_i;

	int errors = 0;
	int cycles = 0;

	tb_clk_gen u_clk (.clk_o(clk_i), .rst_no(rst_ni));

	ctrl_top #(.NumFastIrq(NumFastIrq)) u_dut (.*);

	always @(posedge clk_i) begin
		cycles <= cycles + 1;
		if (cycles >= CycleLimit) begin
			$display("timeout: run did not finish within %0d cycles", CycleLimit);
			$display("sim failed");
			$finish;
		end
	end

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	// flag order is {fetch, illegal, ecall, ebreak, store, load}.
	function automatic logic [6:0] exc_cause_model(input logic [5:0] f, input logic [1:0] priv);
		if (f[5]) return 7'h01;
		if (f[4]) return 7'h02;
		if (f[3]) return (priv == 2'b11) ? 7'h0b : 7'h08;
		if (f[2]) return 7'h03;
		if (f[1]) return 7'h07;
		return 7'h05;
	endfunction

	function automatic logic [31:0] mtval_model(input logic [5:0] f);
		if (f[5]) return instr_fetch_err_plus2_i ? pc_id_i + 32'd2 : pc_id_i;
		if (f[4]) return instr_is_compressed_i ? {16'h0000, instr_compressed_i} : instr_i;
		if (f[3] || f[2]) return 32'h0;
		return lsu_addr_last_i;
	endfunction

	function automatic logic [6:0] irq_cause_model(input logic [NumFastIrq+2:0] r);
		for (int i = 0; i < NumFastIrq; i++) begin
			if (r[i]) return {2'b01, 5'(16 + i)};
		end
		if (r[NumFastIrq]) return 7'h2b;
		if (r[NumFastIrq+2]) return 7'h23;
		return 7'h27;
	endfunction

	task automatic clear_inputs();
		{instr_valid_i, illegal_insn_i, ecall_insn_i, ebrk_insn_i, instr_fetch_err_i} = '0;
		{mret_insn_i, wfi_insn_i, csr_pipe_flush_i, branch_set_i, jump_set_i} = '0;
		{load_err_i, store_err_i, irq_pending_i, irq_nm_i, stall_id_i} = '0;
		irqs_i = '0;
	endtask

	task automatic wait_irq_taken();
		int n;
		n = 0;
		while (!csr_save_cause_o && n < 20) begin
			@(negedge clk_i);
			#2;
			n++;
		end
		if (!csr_save_cause_o) begin
			$display("interrupt was not taken within 20 cycles at %0t", $time);
			errors++;
		end
	endtask

	task automatic random_stall();
		int n;
		n = $urandom_range(0, 3);
		for (int k = 0; k < n; k++) begin
			@(negedge clk_i);
			stall_id_i = 1'b1;
			#2;
			check_eq("id_in_ready_o", 32'(id_in_ready_o), 32'd0);
		end
		@(negedge clk_i);
		stall_id_i = 1'b0;
		#2;
	endtask

	task automatic raise_exception();
		logic [5:0] fl;
		int nst;
		logic [6:0] exp_cause;
		logic [31:0] exp_mtval;
		@(negedge clk_i);
		priv_mode_i = ($urandom_range(0, 1) != 0) ? ctrl_pkg::PRIV_M : ctrl_pkg::PRIV_U;
		fl = 6'($urandom);
		if (fl == 6'd0) fl = 6'b010000;
		{instr_fetch_err_i, illegal_insn_i, ecall_insn_i, ebrk_insn_i, store_err_i, load_err_i} = fl;
		pc_id_i = $urandom;
		instr_i = $urandom;
		instr_compressed_i = 16'($urandom);
		instr_is_compressed_i = 1'($urandom);
		instr_fetch_err_plus2_i = 1'($urandom);
		lsu_addr_last_i = $urandom;
		instr_valid_i = 1'b1;
		nst = $urandom_range(0, 3);
		stall_id_i = (nst > 0);
		#2;
		exp_cause = exc_cause_model(fl, priv_mode_i);
		exp_mtval = mtval_model(fl);
		for (int k = 0; k < nst; k++) begin
			check_eq("id_in_ready_o", 32'(id_in_ready_o), 32'd0);
			check_eq("pc_set_o", 32'(pc_set_o), 32'd0);
			@(negedge clk_i);
			if (k == nst - 1) stall_id_i = 1'b0;
			#2;
		end
		// the faulting instruction is held in ID until the flush.
		check_eq("id_in_ready_o", 32'(id_in_ready_o), 32'd0);
		check_eq("instr_valid_clear_o", 32'(instr_valid_clear_o), 32'd0);
		check_eq("flush_id_o", 32'(flush_id_o), 32'd0);
		@(negedge clk_i);
		load_err_i = 1'b0; // lsu errors are single-cycle pulses.
		store_err_i = 1'b0;
		#2;
		check_eq("pc_set_o", 32'(pc_set_o), 32'd1);
		check_eq("pc_mux_o", 32'(pc_mux_o), 32'(ctrl_pkg::PC_EXC));
		check_eq("exc_pc_mux_o", 32'(exc_pc_mux_o), 32'(ctrl_pkg::EXC_PC_EXC));
		check_eq("csr_save_id_o", 32'(csr_save_id_o), 32'd1);
		check_eq("csr_save_if_o", 32'(csr_save_if_o), 32'd0);
		check_eq("csr_save_cause_o", 32'(csr_save_cause_o), 32'd1);
		check_eq("exc_cause_o", 32'(exc_cause_o.raw), 32'(exp_cause));
		check_eq("csr_mtval_o", csr_mtval_o, exp_mtval);
		check_eq("flush_id_o", 32'(flush_id_o), 32'd1);
		check_eq("instr_valid_clear_o", 32'(instr_valid_clear_o), 32'd1);
		@(negedge clk_i);
		clear_inputs();
		#2;
	endtask

	task automatic take_branch();
		@(negedge clk_i);
		instr_valid_i = 1'b1;
		if ($urandom_range(0, 1) != 0) branch_set_i = 1'b1;
		else jump_set_i = 1'b1;
		#2;
		check_eq("pc_set_o", 32'(pc_set_o), 32'd1);
		check_eq("pc_mux_o", 32'(pc_mux_o), 32'(ctrl_pkg::PC_JUMP));
		check_eq("id_in_ready_o", 32'(id_in_ready_o), 32'd1);
		check_eq("instr_valid_clear_o", 32'(instr_valid_clear_o), 32'd1);
		@(negedge clk_i);
		clear_inputs();
		#2;
	endtask

	task automatic take_interrupt();
		logic [31:0] r32;
		logic [NumFastIrq+2:0] r;
		logic en;
		@(negedge clk_i);
		csr_mstatus_mie_i = 1'($urandom);
		priv_mode_i = ($urandom_range(0, 1) != 0) ? ctrl_pkg::PRIV_M : ctrl_pkg::PRIV_U;
		r32 = $urandom & $urandom & $urandom; // sparse mask that now and then has several sources.
		r = r32[NumFastIrq+2:0];
		irqs_i = r;
		irq_pending_i = |r;
		#2;
		en = csr_mstatus_mie_i | (priv_mode_i == ctrl_pkg::PRIV_U);
		if ((|r) && en) begin
			wait_irq_taken();
			check_eq("pc_set_o", 32'(pc_set_o), 32'd1);
			check_eq("pc_mux_o", 32'(pc_mux_o), 32'(ctrl_pkg::PC_EXC));
			check_eq("exc_pc_mux_o", 32'(exc_pc_mux_o), 32'(ctrl_pkg::EXC_PC_IRQ));
			check_eq("csr_save_if_o", 32'(csr_save_if_o), 32'd1);
			check_eq("csr_save_id_o", 32'(csr_save_id_o), 32'd0);
			check_eq("exc_cause_o", 32'(exc_cause_o.raw), 32'(irq_cause_model(r)));
		end else begin
			for (int k = 0; k < 6; k++) begin
				check_eq("csr_save_cause_o", 32'(csr_save_cause_o), 32'd0);
				@(negedge clk_i);
				#2;
			end
		end
		@(negedge clk_i);
		clear_inputs();
		#2;
	endtask

	task automatic nmi_and_mret();
		@(negedge clk_i);
		irq_nm_i = 1'b1;
		#2;
		wait_irq_taken();
		check_eq("exc_cause_o", 32'(exc_cause_o.raw), 32'h3f);
		@(negedge clk_i);
		irq_nm_i = 1'b0;
		csr_mstatus_mie_i = 1'b1;
		irqs_i[NumFastIrq] = 1'b1;
		irq_pending_i = 1'b1;
		// nmi mode masks the pending external irq.
		for (int k = 0; k < 4; k++) begin
			#2;
			check_eq("nmi_mode_o", 32'(nmi_mode_o), 32'd1);
			check_eq("csr_save_cause_o", 32'(csr_save_cause_o), 32'd0);
			@(negedge clk_i);
		end
		clear_inputs();
		instr_valid_i = 1'b1;
		mret_insn_i = 1'b1;
		#2;
		check_eq("id_in_ready_o", 32'(id_in_ready_o), 32'd0);
		@(negedge clk_i);
		#2;
		check_eq("pc_set_o", 32'(pc_set_o), 32'd1);
		check_eq("pc_mux_o", 32'(pc_mux_o), 32'(ctrl_pkg::PC_ERET));
		check_eq("csr_restore_mret_o", 32'(csr_restore_mret_o), 32'd1);
		@(negedge clk_i);
		clear_inputs();
		#2;
		check_eq("nmi_mode_o", 32'(nmi_mode_o), 32'd0);
	endtask

	task automatic sleep_and_wake();
		@(negedge clk_i);
		instr_valid_i = 1'b1;
		wfi_insn_i = 1'b1;
		#2;
		check_eq("id_in_ready_o", 32'(id_in_ready_o), 32'd0);
		@(negedge clk_i);
		#2;
		check_eq("pc_set_o", 32'(pc_set_o), 32'd0);
		@(negedge clk_i);
		clear_inputs();
		#2;
		check_eq("ctrl_busy_o", 32'(ctrl_busy_o), 32'd0);
		@(negedge clk_i);
		#2;
		check_eq("ctrl_busy_o", 32'(ctrl_busy_o), 32'd0);
		check_eq("flush_id_o", 32'(flush_id_o), 32'd1);
		@(negedge clk_i);
		csr_mstatus_mie_i = 1'b1;
		irqs_i[NumFastIrq+1] = 1'b1;
		irq_pending_i = 1'b1;
		#2;
		check_eq("ctrl_busy_o", 32'(ctrl_busy_o), 32'd1);
		wait_irq_taken();
		check_eq("exc_cause_o", 32'(exc_cause_o.raw), 32'h27);
		@(negedge clk_i);
		clear_inputs();
		#2;
	endtask

	initial begin
		void'($urandom(77775));
		clear_inputs();
		instr_i = '0;
		instr_compressed_i = '0;
		instr_is_compressed_i = 1'b0;
		instr_fetch_err_plus2_i = 1'b0;
		pc_id_i = '0;
		lsu_addr_last_i = '0;
		csr_mstatus_mie_i = 1'b0;
		priv_mode_i = ctrl_pkg::PRIV_M;

		wait (rst_ni == 1'b1);
		#2;
		check_eq("pc_set_o", 32'(pc_set_o), 32'd0);
		check_eq("instr_req_o", 32'(instr_req_o), 32'd0);
		@(negedge clk_i);
		#2;
		check_eq("pc_set_o", 32'(pc_set_o), 32'd1);
		check_eq("pc_mux_o", 32'(pc_mux_o), 32'(ctrl_pkg::PC_BOOT));
		check_eq("instr_req_o", 32'(instr_req_o), 32'd0);
		@(negedge clk_i);
		#2;
		check_eq("pc_set_o", 32'(pc_set_o), 32'd1);
		check_eq("pc_mux_o", 32'(pc_mux_o), 32'(ctrl_pkg::PC_BOOT));
		check_eq("instr_req_o", 32'(instr_req_o), 32'd1);
		@(negedge clk_i);
		#2;
		check_eq("pc_set_o", 32'(pc_set_o), 32'd0);
		check_eq("id_in_ready_o", 32'(id_in_ready_o), 32'd1);

		for (int t = 0; t < NumTxn; t++) begin
			random_stall();
			case ($urandom_range(0, 4))
				0: raise_exception();
				1: take_branch();
				2: take_interrupt();
				3: nmi_and_mret();
				default: sleep_and_wake();
			endcase
		end

		$display("errors: %0d after %0d transactions", errors, NumTxn);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

/* tb_clk_gen.sv */
`timescale 1ns/10ps

module tb_clk_gen (
	output logic clk_o,
	output logic rst_no
);

	initial begin
		clk_o  = 1'b0;
		rst_no = 1'b0;
		repeat (2) @(posedge clk_o);
		@(negedge clk_o);
		rst_no = 1'b1; // released away from the active edge.
	end

	always #5 clk_o = ~clk_o;

endmodule

/* ctrl_properties.sv */
`timescale 1ns/10ps

module ctrl_properties (
	input logic clk_i,
	input logic rst_ni,
	input logic pc_set_o,
	input logic instr_req_o,
	input logic csr_save_cause_o,
	input logic nmi_mode_o,
	input logic irq_nm_i
);

	// nothing is fetched or redirected while reset is held.
	quiet_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !pc_set_o && !instr_req_o)
		else $error("pc_set_o or instr_req_o high during reset");

	save_cause_sets_pc: assert property (@(posedge clk_i) disable iff (!rst_ni)
		csr_save_cause_o |-> pc_set_o)
		else $error("csr_save_cause_o without pc_set_o");

	// nmi mode is entered one cycle after the taken nmi.
	nmi_mode_after_nmi: assert property (@(posedge clk_i) disable iff (!rst_ni)
		$rose(nmi_mode_o) |-> $past(irq_nm_i))
		else $error("nmi_mode_o rose without irq_nm_i");

endmodule

bind ctrl_top ctrl_properties u_props (
	.clk_i            (clk_i),
	.rst_ni           (rst_ni),
	.pc_set_o         (pc_set_o),
	.instr_req_o      (instr_req_o),
	.csr_save_cause_o (csr_save_cause_o),
	.nmi_mode_o       (nmi_mode_o),
	.irq_nm_i         (irq_nm_i)
);

/* ctrl_top.sv */
`timescale 1ns/10ps

module ctrl_top #(
	parameter int unsigned NumFastIrq = 15 // 1 to 16.
) (
	input  logic                  clk_i,
	input  logic                  rst_ni,
	output logic                  ctrl_busy_o,
	input  logic                  illegal_insn_i,
	input  logic                  ecall_insn_i,
	input  logic                  mret_insn_i,
	input  logic                  wfi_insn_i,
	input  logic                  ebrk_insn_i,
	input  logic                  csr_pipe_flush_i,
	input  logic                  instr_valid_i,
	input  logic [31:0]           instr_i,
	input  logic [15:0]           instr_compressed_i,
	input  logic                  instr_is_compressed_i,
	input  logic                  instr_fetch_err_i,
	input  logic                  instr_fetch_err_plus2_i,
	input  logic [31:0]           pc_id_i,
	output logic                  instr_valid_clear_o,
	output logic                  id_in_ready_o,
	output logic                  instr_req_o,
	output logic                  pc_set_o,
	output ctrl_pkg::pc_sel_e     pc_mux_o,
	output ctrl_pkg::exc_pc_sel_e exc_pc_mux_o,
	output ctrl_pkg::exc_cause_t  exc_cause_o,
	input  logic [31:0]           lsu_addr_last_i,
	input  logic                  load_err_i,
	input  logic                  store_err_i,
	input  logic                  branch_set_i,
	input  logic                  jump_set_i,
	input  logic                  csr_mstatus_mie_i,
	input  logic                  irq_pending_i,
	input  logic [NumFastIrq+2:0] irqs_i,
	input  logic                  irq_nm_i,
	output logic                  nmi_mode_o,
	output logic                  csr_save_if_o,
	output logic                  csr_save_id_o,
	output logic                  csr_save_cause_o,
	output logic                  csr_restore_mret_o,
	output logic [31:0]           csr_mtval_o,
	input  logic [1:0]            priv_mode_i,
	input  logic                  stall_id_i,
	output logic                  flush_id_o
);

	logic                 exc_req;
	logic                 exc_pending;
	logic [5:0]           prio;
	logic                 in_flush;
	logic                 handle_irq;
	ctrl_pkg::exc_cause_t irq_cause;
	logic                 nmi_enter;
	logic                 nmi_exit;

	ctrl_exc_prio u_exc_prio (
		.clk_i             (clk_i),
		.rst_ni            (rst_ni),
		.instr_valid_i     (instr_valid_i),
		.illegal_insn_i    (illegal_insn_i),
		.ecall_insn_i      (ecall_insn_i),
		.ebrk_insn_i       (ebrk_insn_i),
		.instr_fetch_err_i (instr_fetch_err_i),
		.load_err_i        (load_err_i),
		.store_err_i       (store_err_i),
		.in_flush_i        (in_flush),
		.exc_req_o         (exc_req),
		.exc_pending_o     (exc_pending),
		.prio_o            (prio)
	);

	ctrl_irq #(
		.NumFastIrq (NumFastIrq)
	) u_irq (
		.clk_i             (clk_i),
		.rst_ni            (rst_ni),
		.irqs_i            (irqs_i),
		.irq_pending_i     (irq_pending_i),
		.irq_nm_i          (irq_nm_i),
		.csr_mstatus_mie_i (csr_mstatus_mie_i),
		.priv_mode_i       (priv_mode_i),
		.nmi_enter_i       (nmi_enter),
		.nmi_exit_i        (nmi_exit),
		.handle_irq_o      (handle_irq),
		.irq_cause_o       (irq_cause),
		.nmi_mode_o        (nmi_mode_o)
	);

	ctrl_fsm u_fsm (
		.clk_i                   (clk_i),
		.rst_ni                  (rst_ni),
		.instr_valid_i           (instr_valid_i),
		.mret_insn_i             (mret_insn_i),
		.wfi_insn_i              (wfi_insn_i),
		.csr_pipe_flush_i        (csr_pipe_flush_i),
		.instr_i                 (instr_i),
		.instr_compressed_i      (instr_compressed_i),
		.instr_is_compressed_i   (instr_is_compressed_i),
		.instr_fetch_err_plus2_i (instr_fetch_err_plus2_i),
		.pc_id_i                 (pc_id_i),
		.lsu_addr_last_i         (lsu_addr_last_i),
		.branch_set_i            (branch_set_i),
		.jump_set_i              (jump_set_i),
		.stall_id_i              (stall_id_i),
		.irq_pending_i           (irq_pending_i),
		.irq_nm_i                (irq_nm_i),
		.priv_mode_i             (priv_mode_i),
		.exc_req_i               (exc_req),
		.exc_pending_i           (exc_pending),
		.prio_i                  (prio),
		.handle_irq_i            (handle_irq),
		.irq_cause_i             (irq_cause),
		.nmi_mode_i              (nmi_mode_o),
		.ctrl_busy_o             (ctrl_busy_o),
		.instr_req_o             (instr_req_o),
		.pc_set_o                (pc_set_o),
		.pc_mux_o                (pc_mux_o),
		.exc_pc_mux_o            (exc_pc_mux_o),
		.exc_cause_o             (exc_cause_o),
		.csr_mtval_o             (csr_mtval_o),
		.csr_save_if_o           (csr_save_if_o),
		.csr_save_id_o           (csr_save_id_o),
		.csr_save_cause_o        (csr_save_cause_o),
		.csr_restore_mret_o      (csr_restore_mret_o),
		.id_in_ready_o           (id_in_ready_o),
		.instr_valid_clear_o     (instr_valid_clear_o),
		.flush_id_o              (flush_id_o),
		.in_flush_o              (in_flush),
		.nmi_enter_o             (nmi_enter),
		.nmi_exit_o              (nmi_exit)
	);

endmodule

/* ctrl_fsm.sv */
`timescale 1ns/10ps

module ctrl_fsm (
	input  logic                    clk_i,
	input  logic                    rst_ni,
	input  logic                    instr_valid_i,
	input  logic                    mret_insn_i,
	input  logic                    wfi_insn_i,
	input  logic                    csr_pipe_flush_i,
	input  logic [31:0]             instr_i,
	input  logic [15:0]             instr_compressed_i,
	input  logic                    instr_is_compressed_i,
	input  logic                    instr_fetch_err_plus2_i,
	input  logic [31:0]             pc_id_i,
	input  logic [31:0]             lsu_addr_last_i,
	input  logic                    branch_set_i,
	input  logic                    jump_set_i,
	input  logic                    stall_id_i,
	input  logic                    irq_pending_i,
	input  logic                    irq_nm_i,
	input  logic [1:0]              priv_mode_i,
	input  logic                    exc_req_i,
	input  logic                    exc_pending_i,
	input  logic [5:0]              prio_i,
	input  logic                    handle_irq_i,
	input  ctrl_pkg::exc_cause_t    irq_cause_i,
	input  logic                    nmi_mode_i,
	output logic                    ctrl_busy_o,
	output logic                    instr_req_o,
	output logic                    pc_set_o,
	output ctrl_pkg::pc_sel_e       pc_mux_o,
	output ctrl_pkg::exc_pc_sel_e   exc_pc_mux_o,
	output ctrl_pkg::exc_cause_t    exc_cause_o,
	output logic [31:0]             csr_mtval_o,
	output logic                    csr_save_if_o,
	output logic                    csr_save_id_o,
	output logic                    csr_save_cause_o,
	output logic                    csr_restore_mret_o,
	output logic                    id_in_ready_o,
	output logic                    instr_valid_clear_o,
	output logic                    flush_id_o,
	output logic                    in_flush_o,
	output logic                    nmi_enter_o,
	output logic                    nmi_exit_o
);

	ctrl_pkg::ctrl_state_e state_q;
	ctrl_pkg::ctrl_state_e state_d;

	logic boot_q;
	logic halt_if;
	logic retain_id;
	logic flush_id;
	logic mret_insn;
	logic special_req;

	assign mret_insn = mret_insn_i & instr_valid_i;

	// anything that has to leave DECODE through FLUSH.
	assign special_req = exc_req_i |
		(instr_valid_i & (mret_insn_i | wfi_insn_i | csr_pipe_flush_i));

	always_comb begin
		state_d            = state_q;
		ctrl_busy_o        = 1'b1;
		instr_req_o        = 1'b1;
		pc_set_o           = 1'b0;
		pc_mux_o           = ctrl_pkg::PC_BOOT;
		exc_pc_mux_o       = ctrl_pkg::EXC_PC_EXC;
		exc_cause_o.raw    = '0;
		csr_mtval_o        = '0;
		csr_save_if_o      = 1'b0;
		csr_save_id_o      = 1'b0;
		csr_save_cause_o   = 1'b0;
		csr_restore_mret_o = 1'b0;
		halt_if            = 1'b0;
		retain_id          = 1'b0;
		flush_id           = 1'b0;
		nmi_enter_o        = 1'b0;
		nmi_exit_o         = 1'b0;

		case (state_q)
			ctrl_pkg::RESET: begin
				instr_req_o = 1'b0;
				state_d     = ctrl_pkg::BOOT_SET;
			end

			// two cycles at the boot address, fetch starts in the second.
			ctrl_pkg::BOOT_SET: begin
				pc_set_o    = 1'b1;
				pc_mux_o    = ctrl_pkg::PC_BOOT;
				instr_req_o = boot_q;
				if (boot_q) begin
					state_d = ctrl_pkg::FIRST_FETCH;
				end
			end

			ctrl_pkg::WAIT_SLEEP: begin
				ctrl_busy_o = 1'b0;
				instr_req_o = 1'b0;
				halt_if     = 1'b1;
				flush_id    = 1'b1;
				state_d     = ctrl_pkg::SLEEP;
			end

			ctrl_pkg::SLEEP: begin
				instr_req_o = 1'b0;
				halt_if     = 1'b1;
				flush_id    = 1'b1;
				if (irq_nm_i || irq_pending_i) begin
					state_d = ctrl_pkg::FIRST_FETCH; // wake up, clock gate opens.
				end else begin
					ctrl_busy_o = 1'b0;
				end
			end

			ctrl_pkg::FIRST_FETCH: begin
				if (id_in_ready_o) begin
					state_d = ctrl_pkg::DECODE;
				end
			end

			ctrl_pkg::DECODE: begin
				pc_mux_o = ctrl_pkg::PC_JUMP;
				if (special_req) begin
					retain_id = 1'b1;
					if (!stall_id_i) begin
						state_d = ctrl_pkg::FLUSH;
					end
				end
				if (branch_set_i || jump_set_i) begin
					pc_set_o = 1'b1;
				end
				// irqs wait for an empty, unstalled ID stage.
				if (handle_irq_i && (stall_id_i || instr_valid_i)) begin
					halt_if = 1'b1;
				end
				if (handle_irq_i && !stall_id_i && !special_req && !instr_valid_i) begin
					halt_if = 1'b1;
					state_d = ctrl_pkg::IRQ_TAKEN;
				end
			end

			ctrl_pkg::IRQ_TAKEN: begin
				pc_mux_o     = ctrl_pkg::PC_EXC;
				exc_pc_mux_o = ctrl_pkg::EXC_PC_IRQ;
				if (handle_irq_i) begin
					pc_set_o         = 1'b1;
					csr_save_if_o    = 1'b1;
					csr_save_cause_o = 1'b1;
					exc_cause_o      = irq_cause_i;
					nmi_enter_o      = irq_nm_i & ~nmi_mode_i;
				end
				state_d = ctrl_pkg::DECODE;
			end

			ctrl_pkg::FLUSH: begin
				halt_if  = 1'b1;
				flush_id = 1'b1;
				state_d  = ctrl_pkg::DECODE;
				if (exc_pending_i) begin
					pc_set_o         = 1'b1;
					pc_mux_o         = ctrl_pkg::PC_EXC;
					exc_pc_mux_o     = ctrl_pkg::EXC_PC_EXC;
					csr_save_id_o    = 1'b1;
					csr_save_cause_o = 1'b1;
					case (1'b1)
						prio_i[5]: begin
							exc_cause_o.raw = ctrl_pkg::EXC_CAUSE_INSTR_ACCESS_FAULT;
							csr_mtval_o     = instr_fetch_err_plus2_i ? pc_id_i + 32'd2 : pc_id_i;
						end
						prio_i[4]: begin
							exc_cause_o.raw = ctrl_pkg::EXC_CAUSE_ILLEGAL_INSN;
							csr_mtval_o     = instr_is_compressed_i ?
								{16'h0000, instr_compressed_i} : instr_i;
						end
						prio_i[3]: begin
							exc_cause_o.raw = (priv_mode_i == ctrl_pkg::PRIV_M) ?
								ctrl_pkg::EXC_CAUSE_ECALL_M_MODE : ctrl_pkg::EXC_CAUSE_ECALL_U_MODE;
						end
						prio_i[2]: begin
							exc_cause_o.raw = ctrl_pkg::EXC_CAUSE_BREAKPOINT;
						end
						prio_i[1]: begin
							exc_cause_o.raw = ctrl_pkg::EXC_CAUSE_STORE_ACCESS_FAULT;
							csr_mtval_o     = lsu_addr_last_i;
						end
						prio_i[0]: begin
							exc_cause_o.raw = ctrl_pkg::EXC_CAUSE_LOAD_ACCESS_FAULT;
							csr_mtval_o     = lsu_addr_last_i;
						end
						default: begin
							exc_cause_o.raw = '0;
						end
					endcase
				end else if (mret_insn) begin
					pc_set_o           = 1'b1;
					pc_mux_o           = ctrl_pkg::PC_ERET;
					csr_restore_mret_o = 1'b1;
					nmi_exit_o         = nmi_mode_i;
				end else if (wfi_insn_i && instr_valid_i) begin
					state_d = ctrl_pkg::WAIT_SLEEP;
				end
			end

			default: begin
				instr_req_o = 1'b0;
				state_d     = ctrl_pkg::RESET;
			end
		endcase
	end

	assign in_flush_o          = (state_q == ctrl_pkg::FLUSH);
	assign flush_id_o          = flush_id;
	assign id_in_ready_o       = ~stall_id_i & ~halt_if & ~retain_id;
	assign instr_valid_clear_o = ~(stall_id_i | retain_id) | flush_id;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q <= ctrl_pkg::RESET;
			boot_q  <= 1'b0;
		end else begin
			state_q <= state_d;
			boot_q  <= (state_q == ctrl_pkg::BOOT_SET) & ~boot_q;
		end
	end

endmodule

/* ctrl_irq.sv */
`timescale 1ns/10ps

module ctrl_irq #(
	parameter int unsigned NumFastIrq = 15
) (
	input  logic                 clk_i,
	input  logic                 rst_ni,
	input  logic [NumFastIrq+2:0] irqs_i,
	input  logic                 irq_pending_i,
	input  logic                 irq_nm_i,
	input  logic                 csr_mstatus_mie_i,
	input  logic [1:0]           priv_mode_i,
	input  logic                 nmi_enter_i,
	input  logic                 nmi_exit_i,
	output logic                 handle_irq_o,
	output ctrl_pkg::exc_cause_t irq_cause_o,
	output logic                 nmi_mode_o
);

	localparam int unsigned IrqExt = NumFastIrq;
	localparam int unsigned IrqTimer = NumFastIrq + 1;
	localparam int unsigned IrqSoft = NumFastIrq + 2;

	logic       irq_enabled;
	logic       nmi_mode_q;
	logic [4:0] fast_id;

	// user mode code can always be interrupted.
	assign irq_enabled = csr_mstatus_mie_i | (priv_mode_i == ctrl_pkg::PRIV_U);

	assign handle_irq_o = ~nmi_mode_q & (irq_nm_i | (irq_pending_i & irq_enabled));
	assign nmi_mode_o   = nmi_mode_q;

	// lowest pending fast interrupt.
	always_comb begin
		fast_id = '0;
		for (int i = NumFastIrq - 1; i >= 0; i--) begin
			if (irqs_i[i]) begin
				fast_id = 5'(i);
			end
		end
	end

	always_comb begin
		irq_cause_o.raw = '0;
		if (irq_nm_i) begin
			irq_cause_o.raw = ctrl_pkg::EXC_CAUSE_IRQ_NM;
		end else if (|irqs_i[NumFastIrq-1:0]) begin
			irq_cause_o.fields.irq      = 1'b0;
			irq_cause_o.fields.internal = 1'b1;
			irq_cause_o.fields.code     = ctrl_pkg::FAST_IRQ_CODE_BASE + fast_id;
		end else if (irqs_i[IrqExt]) begin
			irq_cause_o.raw = ctrl_pkg::EXC_CAUSE_IRQ_EXTERNAL;
		end else if (irqs_i[IrqSoft]) begin
			irq_cause_o.raw = ctrl_pkg::EXC_CAUSE_IRQ_SOFTWARE;
		end else if (irqs_i[IrqTimer]) begin
			irq_cause_o.raw = ctrl_pkg::EXC_CAUSE_IRQ_TIMER;
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			nmi_mode_q <= 1'b0;
		end else if (nmi_enter_i) begin
			nmi_mode_q <= 1'b1;
		end else if (nmi_exit_i) begin
			nmi_mode_q <= 1'b0; // left by mret.
		end
	end

endmodule

/* ctrl_exc_prio.sv */
`timescale 1ns/10ps

module ctrl_exc_prio (
	input  logic       clk_i,
	input  logic       rst_ni,
	input  logic       instr_valid_i,
	input  logic       illegal_insn_i,
	input  logic       ecall_insn_i,
	input  logic       ebrk_insn_i,
	input  logic       instr_fetch_err_i,
	input  logic       load_err_i,
	input  logic       store_err_i,
	input  logic       in_flush_i,
	output logic       exc_req_o,
	output logic       exc_pending_o,
	output logic [5:0] prio_o
);

	logic fetch_err;
	logic ecall;
	logic ebrk;
	logic illegal_d;
	logic exc_req_d;
	logic illegal_q;
	logic exc_req_q;
	logic load_err_q;
	logic store_err_q;

	assign fetch_err = instr_fetch_err_i & instr_valid_i;
	assign ecall     = ecall_insn_i & instr_valid_i;
	assign ebrk      = ebrk_insn_i & instr_valid_i;

	// the instruction stays in ID during the flush, so do not raise it twice.
	assign illegal_d = illegal_insn_i & instr_valid_i & ~in_flush_i;
	assign exc_req_d = (fetch_err | illegal_d | ecall | ebrk) & ~in_flush_i;

	assign exc_req_o     = exc_req_d | load_err_i | store_err_i; // lsu errors flush too.
	assign exc_pending_o = exc_req_q | load_err_q | store_err_q;

	// {fetch, illegal, ecall, ebreak, store, load}, msb wins.
	always_comb begin
		prio_o = '0;
		if (fetch_err) begin
			prio_o[5] = 1'b1;
		end else if (illegal_q) begin
			prio_o[4] = 1'b1;
		end else if (ecall) begin
			prio_o[3] = 1'b1;
		end else if (ebrk) begin
			prio_o[2] = 1'b1;
		end else if (store_err_q) begin
			prio_o[1] = 1'b1;
		end else if (load_err_q) begin
			prio_o[0] = 1'b1;
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			illegal_q   <= 1'b0;
			exc_req_q   <= 1'b0;
			load_err_q  <= 1'b0;
			store_err_q <= 1'b0;
		end else begin
			illegal_q   <= illegal_d;
			exc_req_q   <= exc_req_d;
			load_err_q  <= load_err_i;
			store_err_q <= store_err_i;
		end
	end

endmodule

/* ctrl_pkg.sv */
package ctrl_pkg;

	typedef enum logic [3:0] {
		RESET,
		BOOT_SET,
		WAIT_SLEEP,
		SLEEP,
		FIRST_FETCH,
		DECODE,
		FLUSH,
		IRQ_TAKEN
	} ctrl_state_e;

	typedef enum logic [2:0] {
		PC_BOOT,
		PC_JUMP,
		PC_EXC,
		PC_ERET
	} pc_sel_e;

	typedef enum logic [1:0] {
		EXC_PC_EXC,
		EXC_PC_IRQ
	} exc_pc_sel_e;

	// mcause as written to the csr file, or split into its fields.
	typedef union packed {
		logic [6:0] raw;
		struct packed {
			logic       irq;
			logic       internal;
			logic [4:0] code;
		} fields;
	} exc_cause_t;

	localparam logic [6:0] EXC_CAUSE_INSTR_ACCESS_FAULT = 7'h01;
	localparam logic [6:0] EXC_CAUSE_ILLEGAL_INSN       = 7'h02;
	localparam logic [6:0] EXC_CAUSE_BREAKPOINT         = 7'h03;
	localparam logic [6:0] EXC_CAUSE_LOAD_ACCESS_FAULT  = 7'h05;
	localparam logic [6:0] EXC_CAUSE_STORE_ACCESS_FAULT = 7'h07;
	localparam logic [6:0] EXC_CAUSE_ECALL_U_MODE       = 7'h08;
	localparam logic [6:0] EXC_CAUSE_ECALL_M_MODE       = 7'h0b;

	localparam logic [6:0] EXC_CAUSE_IRQ_SOFTWARE = 7'h23;
	localparam logic [6:0] EXC_CAUSE_IRQ_TIMER    = 7'h27;
	localparam logic [6:0] EXC_CAUSE_IRQ_EXTERNAL = 7'h2b;
	localparam logic [6:0] EXC_CAUSE_IRQ_NM       = 7'h3f;

	localparam logic [4:0] FAST_IRQ_CODE_BASE = 5'd16; // fast irq i uses code 16+i.

	localparam logic [1:0] PRIV_M = 2'b11;
	localparam logic [1:0] PRIV_U = 2'b00;

endpackage
